/* verilog/aes_chunk_macros.svh */
`ifndef AES_CHUNK_MACROS_SVH
`define AES_CHUNK_MACROS_SVH

////////////////////
// BRAM side
////////////////////

// Data and address width of the BRAM port
`define AES_WORD_W 32

// Byte stride between consecutive chunks
`define AES_CHUNK_BYTES 32

////////////////////
// Cipher side
////////////////////

// Words per lane block, four words make one 128-bit block
`define AES_LANE_WORDS 4

`define AES_LANES 2

`define AES_KEY_W 256

`endif

/* verilog/aes_chunk_pkg.sv */
`include "aes_chunk_macros.svh"

package aes_chunk_pkg;

    ////////////////////
    // Data types
    ////////////////////

    typedef logic [`AES_WORD_W-1:0] word_t;

    // Word 0 of a lane sits in the top bits
    typedef logic [`AES_LANE_WORDS*`AES_WORD_W-1:0] block_t;

    typedef logic [`AES_KEY_W-1:0] aes_key_t;

    ////////////////////
    // Control encodings
    ////////////////////

    // Chunk FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_WORD,
        ST_WAIT_READY,
        ST_START_LANE,
        ST_WAIT_RESULT,
        ST_WRITE_WORD
    } seq_state_e;

    // Single-cycle command from the FSM to the word mover
    typedef enum logic [1:0] {
        XFER_NONE,
        XFER_READ,
        XFER_WRITE
    } xfer_op_e;

    // Everything driven towards the BRAM port
    typedef struct packed {
        logic  start_read;
        logic  start_write;
        word_t read_addr;
        word_t write_addr;
        word_t write_data;
    } bram_req_t;

endpackage

/* verilog/chunk_sequencer.sv */
`include "aes_chunk_macros.svh"

module chunk_sequencer
    import aes_chunk_pkg::*;
(
    input  logic                  aes_clk,
    input  logic                  aes_rst_n,
    input  logic                  start,
    input  word_t                 num_chunks,
    input  aes_key_t              key,
    output xfer_op_e              xfer_op,
    output logic [2:0]            word_idx,
    output logic                  next_chunk,
    input  logic                  xfer_done,
    output logic                  load_word,
    output logic [`AES_LANES-1:0] capture_lane,
    output logic                  core_init,
    output logic [`AES_LANES-1:0] core_next,
    input  logic [`AES_LANES-1:0] core_ready,
    output logic                  complete
);

    localparam logic [1:0] LAST_IN_LANE = 2'(`AES_LANE_WORDS - 1);

    seq_state_e state;
    word_t      chunks_left;
    aes_key_t   stored_key;
    logic       lane;
    logic       lane_done;
    logic       last_chunk;
    logic       key_new;

    // Lane index is the top bit of the word counter
    assign lane       = word_idx[2];
    assign lane_done  = (word_idx[1:0] == LAST_IN_LANE);
    assign last_chunk = (chunks_left == word_t'(1));

    // Zero key means nothing loaded into the cores yet
    assign key_new = (key != stored_key) || (stored_key == '0);

    ////////////////////
    // Strobes
    ////////////////////

    assign load_word = (state == ST_READ_WORD) && xfer_done;

    // Seen by the mover on the same edge as the next read command
    assign next_chunk = (state == ST_WRITE_WORD) && xfer_done && (&word_idx) && !last_chunk;

    always_comb begin
        core_next = '0;
        if (state == ST_START_LANE) begin
            core_next[lane] = 1'b1;
        end
    end

    ////////////////////
    // Chunk FSM
    ////////////////////

    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            state        <= ST_IDLE;
            xfer_op      <= XFER_NONE;
            word_idx     <= '0;
            chunks_left  <= '0;
            stored_key   <= '0;
            capture_lane <= '0;
            core_init    <= 1'b0;
            complete     <= 1'b0;
        end else begin
            xfer_op      <= XFER_NONE;
            capture_lane <= '0;
            core_init    <= 1'b0;
            complete     <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        chunks_left <= (num_chunks == '0) ? word_t'(1) : num_chunks;
                        word_idx    <= '0;
                        xfer_op     <= XFER_READ;
                        state       <= ST_READ_WORD;
                        if (key_new) begin
                            core_init  <= 1'b1;
                            stored_key <= key;
                        end
                    end
                end

                ST_READ_WORD: begin
                    if (xfer_done) begin
                        if (lane_done) begin
                            state <= ST_WAIT_READY;
                        end else begin
                            word_idx <= word_idx + 3'd1;
                            xfer_op  <= XFER_READ;
                        end
                    end
                end

                ST_WAIT_READY: begin
                    if (core_ready[lane]) begin
                        state <= ST_START_LANE;
                    end
                end

                // next is high for this one cycle, counter wraps 3->4 or 7->0
                ST_START_LANE: begin
                    word_idx <= word_idx + 3'd1;
                    if (!lane) begin
                        xfer_op <= XFER_READ;
                        state   <= ST_READ_WORD;
                    end else begin
                        state <= ST_WAIT_RESULT;
                    end
                end

                ST_WAIT_RESULT: begin
                    if (core_ready[lane]) begin
                        capture_lane[lane] <= 1'b1;
                        xfer_op            <= XFER_WRITE;
                        state              <= ST_WRITE_WORD;
                    end
                end

                ST_WRITE_WORD: begin
                    if (xfer_done) begin
                        word_idx <= word_idx + 3'd1;
                        if (!lane_done) begin
                            xfer_op <= XFER_WRITE;
                        end else if (!lane) begin
                            state <= ST_WAIT_RESULT;
                        end else if (!last_chunk) begin
                            chunks_left <= chunks_left - word_t'(1);
                            xfer_op     <= XFER_READ;
                            state       <= ST_READ_WORD;
                        end else begin
                            complete <= 1'b1;
                            state    <= ST_IDLE;
                        end
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/bram_word_mover.sv */
`include "aes_chunk_macros.svh"

module bram_word_mover
    import aes_chunk_pkg::*;
(
    input  logic       aes_clk,
    input  logic       aes_rst_n,
    input  word_t      read_base,
    input  word_t      write_base,
    input  logic       start,
    input  logic       next_chunk,
    input  xfer_op_e   xfer_op,
    input  logic [2:0] word_idx,
    input  logic       bram_complete,
    output bram_req_t  req_fields,
    output logic       xfer_done
);

    word_t rd_base;
    word_t wr_base;
    word_t rd_addr;
    word_t wr_addr;
    word_t word_off;
    logic  start_read;
    logic  start_write;
    logic  run_active;
    logic  load_bases;
    logic  last_write;

    assign word_off   = word_t'({word_idx, 2'b00});
    assign xfer_done  = (start_read || start_write) && bram_complete;
    assign load_bases = start && !run_active;
    assign last_write = start_write && (&word_idx);

    // Tracks the FSM's busy period so a held start does not reload the bases
    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            run_active  <= 1'b0;
            start_read  <= 1'b0;
            start_write <= 1'b0;
        end else begin
            if (load_bases) begin
                run_active <= 1'b1;
            end else if (xfer_done && last_write && !next_chunk) begin
                run_active <= 1'b0;
            end

            // Strobe up the cycle after the command, down after complete
            if (xfer_op == XFER_READ) begin
                start_read <= 1'b1;
            end else if (start_read && bram_complete) begin
                start_read <= 1'b0;
            end

            if (xfer_op == XFER_WRITE) begin
                start_write <= 1'b1;
            end else if (start_write && bram_complete) begin
                start_write <= 1'b0;
            end
        end
    end

    always_ff @(posedge aes_clk) begin
        if (load_bases) begin
            rd_base <= read_base;
            wr_base <= write_base;
        end else if (next_chunk) begin
            rd_base <= rd_base + word_t'(`AES_CHUNK_BYTES);
            wr_base <= wr_base + word_t'(`AES_CHUNK_BYTES);
        end

        if (xfer_op == XFER_READ) begin
            rd_addr <= rd_base + word_off;
        end
        if (xfer_op == XFER_WRITE) begin
            wr_addr <= wr_base + word_off;
        end
    end

    assign req_fields = '{
        start_read:  start_read,
        start_write: start_write,
        read_addr:   rd_addr,
        write_addr:  wr_addr,
        write_data:  '0
    };

endmodule

/* verilog/block_buffer.sv */
`include "aes_chunk_macros.svh"

module block_buffer
    import aes_chunk_pkg::*;
(
    input  logic                    aes_clk,
    input  logic                    aes_rst_n,
    input  word_t                   bram_read_data,
    input  logic                    load_word,
    input  logic [2:0]              word_idx,
    input  logic [`AES_LANES-1:0]   capture_lane,
    input  block_t [`AES_LANES-1:0] core_result,
    output block_t [`AES_LANES-1:0] core_block,
    output word_t                   write_data
);

    localparam int CHUNK_WORDS = `AES_LANES * `AES_LANE_WORDS;
    localparam int LW          = `AES_LANE_WORDS;
    localparam int W           = `AES_WORD_W;

    word_t in_words  [CHUNK_WORDS];
    word_t res_words [CHUNK_WORDS];

    ////////////////////
    // Read side
    ////////////////////

    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            for (int i = 0; i < CHUNK_WORDS; i++) begin
                in_words[i] <= '0;
            end
        end else if (load_word) begin
            in_words[word_idx] <= bram_read_data;
        end
    end

    // Lane l takes words 4l..4l+3, first word in the top bits
    always_comb begin
        for (int l = 0; l < `AES_LANES; l++) begin
            for (int w = 0; w < LW; w++) begin
                core_block[l][(LW-1-w)*W +: W] = in_words[l*LW + w];
            end
        end
    end

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge aes_clk) begin
        for (int l = 0; l < `AES_LANES; l++) begin
            if (capture_lane[l]) begin
                for (int w = 0; w < LW; w++) begin
                    res_words[l*LW + w] <= core_result[l][(LW-1-w)*W +: W];
                end
            end
        end
    end

    // Stays put while the write strobe is up
    assign write_data = res_words[word_idx];

endmodule

/* verilog/aes_top.sv */
`include "aes_chunk_macros.svh"

module aes_top
    import aes_chunk_pkg::*;
(
    input  logic                    aes_clk,
    input  logic                    aes_rst_n,
    input  logic                    start,
    input  word_t                   num_chunks,
    input  word_t                   read_base,
    input  word_t                   write_base,
    input  aes_key_t                key,
    output bram_req_t               bram_req,
    input  word_t                   bram_read_data,
    input  logic                    bram_complete,
    output logic                    core_init,
    output logic [`AES_LANES-1:0]   core_next,
    input  logic [`AES_LANES-1:0]   core_ready,
    output block_t [`AES_LANES-1:0] core_block,
    input  block_t [`AES_LANES-1:0] core_result,
    output logic                    complete
);

    xfer_op_e              xfer_op;
    logic [2:0]            word_idx;
    logic                  next_chunk;
    logic                  xfer_done;
    logic                  load_word;
    logic [`AES_LANES-1:0] capture_lane;
    bram_req_t             req_fields;
    word_t                 write_data;

    chunk_sequencer u_sequencer (
        .aes_clk      (aes_clk),
        .aes_rst_n    (aes_rst_n),
        .start        (start),
        .num_chunks   (num_chunks),
        .key          (key),
        .xfer_op      (xfer_op),
        .word_idx     (word_idx),
        .next_chunk   (next_chunk),
        .xfer_done    (xfer_done),
        .load_word    (load_word),
        .capture_lane (capture_lane),
        .core_init    (core_init),
        .core_next    (core_next),
        .core_ready   (core_ready),
        .complete     (complete)
    );

    bram_word_mover u_mover (
        .aes_clk       (aes_clk),
        .aes_rst_n     (aes_rst_n),
        .read_base     (read_base),
        .write_base    (write_base),
        .start         (start),
        .next_chunk    (next_chunk),
        .xfer_op       (xfer_op),
        .word_idx      (word_idx),
        .bram_complete (bram_complete),
        .req_fields    (req_fields),
        .xfer_done     (xfer_done)
    );

    block_buffer u_buffer (
        .aes_clk        (aes_clk),
        .aes_rst_n      (aes_rst_n),
        .bram_read_data (bram_read_data),
        .load_word      (load_word),
        .word_idx       (word_idx),
        .capture_lane   (capture_lane),
        .core_result    (core_result),
        .core_block     (core_block),
        .write_data     (write_data)
    );

    // Mover owns strobes and addresses, buffer owns the data
    always_comb begin
        bram_req            = req_fields;
        bram_req.write_data = write_data;
    end

endmodule

/* tb/aes_top_assertions.sv */
`include "aes_chunk_macros.svh"

module aes_top_assertions
    import aes_chunk_pkg::*;
(
    input logic                  aes_clk,
    input logic                  aes_rst_n,
    input bram_req_t             bram_req,
    input logic                  bram_complete,
    input logic                  core_init,
    input logic [`AES_LANES-1:0] core_next,
    input logic [`AES_LANES-1:0] core_ready,
    input logic                  complete
);

    // Read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    ////////////////////
    // BRAM port
    ////////////////////

    one_strobe: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        !(bram_req.start_read && bram_req.start_write))
        else begin
            fail_count++;
            $error("read and write strobes are high together");
        end

    read_held: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        bram_req.start_read && !bram_complete
            |=> bram_req.start_read && $stable(bram_req.read_addr))
        else begin
            fail_count++;
            $error("read strobe or address changed before complete");
        end

    write_held: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        bram_req.start_write && !bram_complete
            |=> bram_req.start_write && $stable(bram_req.write_addr))
        else begin
            fail_count++;
            $error("write strobe or address changed before complete");
        end

    ////////////////////
    // Cores and done
    ////////////////////

    next_with_ready: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        (core_next & ~core_ready) == '0)
        else begin
            fail_count++;
            $error("core_next issued to a lane that is not ready");
        end

    complete_single: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        complete |=> !complete)
        else begin
            fail_count++;
            $error("complete stayed high for more than one cycle");
        end

    // Outputs quiet while reset is held
    reset_quiet: assert property (@(posedge aes_clk)
        !aes_rst_n |-> !bram_req.start_read && !bram_req.start_write && !core_init
            && (core_next == '0) && !complete)
        else begin
            fail_count++;
            $error("control outputs not low during reset");
        end

endmodule

bind aes_top aes_top_assertions u_assert (.*);

/* tb/aes_top_tb.sv */
`include "aes_chunk_macros.svh"

module aes_top_tb
    import aes_chunk_pkg::*;
();

    localparam int MEM_WORDS   = 1024;
    localparam int CHUNK_WORDS = `AES_LANES * `AES_LANE_WORDS;
    localparam int MAX_WORDS   = 4 * CHUNK_WORDS;
    // Eight chunks in all, each well under 200 cycles even with slow BRAM
    localparam int CYCLE_LIMIT = 4000;
    localparam int RECENT_INIT = 16;
    localparam aes_key_t KEY_A = {4{64'h0f1e_2d3c_4b5a_6978}};
    localparam aes_key_t KEY_B = {4{64'h8899_aabb_ccdd_eeff}};

    logic                    aes_clk;
    logic                    aes_rst_n;
    logic                    start;
    word_t                   num_chunks;
    word_t                   read_base;
    word_t                   write_base;
    aes_key_t                key;
    bram_req_t               bram_req;
    word_t                   bram_read_data;
    logic                    bram_complete;
    logic                    core_init;
    logic [`AES_LANES-1:0]   core_next;
    logic [`AES_LANES-1:0]   core_ready;
    block_t [`AES_LANES-1:0] core_block;
    block_t [`AES_LANES-1:0] core_result;
    logic                    complete;

    word_t       mem [MEM_WORDS];
    word_t       exp_words [MAX_WORDS];
    integer      seed;
    int unsigned cycle_count = 0;
    logic        bram_busy;
    int          bram_wait;
    int          init_age;
    int          core_wait [`AES_LANES];
    block_t      core_in [`AES_LANES];
    int          init_cnt;
    int          done_cnt;
    int          read_cnt;
    int          write_cnt;
    int          tests_run;
    int          tests_failed;
    int unsigned assert_fails;

    // Values the DUT sees at the coming rising edge
    bram_req_t               s_req;
    logic [`AES_LANES-1:0]   s_next;
    logic                    s_init;
    block_t [`AES_LANES-1:0] s_block;

    aes_top UUT (.*);

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0000;
    endfunction

    function automatic int mem_index(input word_t addr);
        return int'(addr[11:2]);
    endfunction

    // Stand-in cipher rule
    function automatic block_t cipher_model(input block_t blk, input aes_key_t k, input int lane);
        return blk ^ k[127:0] ^ {`AES_LANE_WORDS{word_t'(lane)}};
    endfunction

    initial aes_clk = 1'b0;
    always #5 aes_clk = ~aes_clk;

    always @(posedge aes_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not complete", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(negedge aes_clk) begin
        s_req   = bram_req;
        s_next  = core_next;
        s_init  = core_init;
        s_block = core_block;
        if (core_init) init_cnt++;
        if (complete) done_cnt++;
        if (bram_complete && bram_req.start_read) read_cnt++;
        if (bram_complete && bram_req.start_write) write_cnt++;
    end

    ////////////////////
    // BRAM model
    ////////////////////

    always @(posedge aes_clk) begin
        #1;
        if (bram_complete) begin
            bram_complete = 1'b0;
            bram_busy     = 1'b0;
        end else if (aes_rst_n && (s_req.start_read || s_req.start_write)) begin
            if (!bram_busy) begin
                bram_busy = 1'b1;
                bram_wait = 1 + ($unsigned($random(seed)) % 4);
            end
            if (bram_wait > 1) begin
                bram_wait--;
            end else begin
                bram_complete = 1'b1;
                if (s_req.start_read) begin
                    bram_read_data = mem[mem_index(s_req.read_addr)];
                end else begin
                    mem[mem_index(s_req.write_addr)] = s_req.write_data;
                end
            end
        end
    end

    ////////////////////
    // Core stand-ins
    ////////////////////

    always @(posedge aes_clk) begin
        #1;
        if (s_init) begin
            init_age = 0;
        end else if (init_age < RECENT_INIT) begin
            init_age++;
        end
        for (int l = 0; l < `AES_LANES; l++) begin
            if (s_next[l]) begin
                core_ready[l] = 1'b0;
                core_in[l]    = s_block[l];
                core_wait[l]  = (init_age < RECENT_INIT) ? 6 : 3;
            end else if (!core_ready[l]) begin
                if (core_wait[l] > 1) begin
                    core_wait[l]--;
                end else begin
                    core_result[l] = cipher_model(core_in[l], key, l);
                    core_ready[l]  = 1'b1;
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge aes_clk);
        #1;
    endtask

    task automatic build_expected(input word_t rbase, input int chunks, input aes_key_t k);
        block_t blk;
        block_t res;
        word_t  addr;
        for (int c = 0; c < chunks; c++) begin
            for (int l = 0; l < `AES_LANES; l++) begin
                for (int w = 0; w < `AES_LANE_WORDS; w++) begin
                    addr = rbase + word_t'(`AES_CHUNK_BYTES * c + 4 * (4 * l + w));
                    blk[(3 - w) * `AES_WORD_W +: `AES_WORD_W] = mem[mem_index(addr)];
                end
                res = cipher_model(blk, k, l);
                for (int w = 0; w < `AES_LANE_WORDS; w++) begin
                    exp_words[c * CHUNK_WORDS + 4 * l + w] = res[(3 - w) * `AES_WORD_W +: `AES_WORD_W];
                end
            end
        end
    endtask

    task automatic run_test(input string name, input word_t rbase, input word_t wbase,
                            input word_t nch, input aes_key_t k, input int exp_init);
        int    chunks;
        int    errs;
        word_t addr;
        word_t got;
        chunks = (nch == '0) ? 1 : int'(nch);
        errs   = 0;
        build_expected(rbase, chunks, k);
        init_cnt   = 0;
        done_cnt   = 0;
        read_cnt   = 0;
        write_cnt  = 0;
        start      = 1'b1;
        num_chunks = nch;
        read_base  = rbase;
        write_base = wbase;
        key        = k;
        next_cycle();
        start = 1'b0;
        while (done_cnt == 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();

        if (init_cnt != exp_init) begin
            $display("%s: core_init pulsed %0d times, expected %0d", name, init_cnt, exp_init);
            errs++;
        end
        if (done_cnt != 1) begin
            $display("%s: complete pulsed %0d times, expected once", name, done_cnt);
            errs++;
        end
        if (read_cnt != chunks * CHUNK_WORDS || write_cnt != chunks * CHUNK_WORDS) begin
            $display("%s: %0d words read and %0d written, expected %0d each", name,
                     read_cnt, write_cnt, chunks * CHUNK_WORDS);
            errs++;
        end
        for (int i = 0; i < chunks * CHUNK_WORDS; i++) begin
            addr = wbase + word_t'(4 * i);
            got  = mem[mem_index(addr)];
            if (got !== exp_words[i]) begin
                $display("Mismatch mem[0x%08h]: got 0x%08h expected 0x%08h", addr, got, exp_words[i]);
                errs++;
            end
        end

        tests_run++;
        if (errs == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        seed           = 32'h20d43c50;
        aes_rst_n      = 1'b1;
        start          = 1'b0;
        num_chunks     = '0;
        read_base      = '0;
        write_base     = '0;
        key            = '0;
        bram_read_data = '0;
        bram_complete  = 1'b0;
        core_ready     = '1;
        core_result    = '0;
        bram_busy      = 1'b0;
        bram_wait      = 0;
        init_age       = RECENT_INIT;
        tests_run      = 0;
        tests_failed   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(word_t'(4 * i));
        end

        #1 aes_rst_n = 1'b0;
        repeat (5) @(posedge aes_clk);
        #1 aes_rst_n = 1'b1;
        repeat (2) next_cycle();

        run_test("test 1 one chunk with new key", 32'h100, 32'h800, 32'd1, KEY_A, 1);
        run_test("test 2 three chunks with same key", 32'h200, 32'h900, 32'd3, KEY_A, 0);
        run_test("test 3 key change", 32'h300, 32'ha00, 32'd1, KEY_B, 1);
        run_test("test 4 two chunks under random BRAM delays", 32'h400, 32'hb00, 32'd2, KEY_B, 0);
        run_test("test 5 zero chunk count after restart", 32'h500, 32'hc00, 32'd0, KEY_B, 0);

        assert_fails = UUT.u_assert.fail_count;
        $display("Summary: %0d tests run, %0d failed, %0d assertion failures",
                 tests_run, tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* aes_top.f */
+incdir+verilog
verilog/aes_chunk_pkg.sv
verilog/chunk_sequencer.sv
verilog/bram_word_mover.sv
verilog/block_buffer.sv
verilog/aes_top.sv
tb/aes_top_assertions.sv
tb/aes_top_tb.sv

/* Bender.yml */
package:
  name: aes_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/aes_chunk_pkg.sv
      - verilog/chunk_sequencer.sv
      - verilog/bram_word_mover.sv
      - verilog/block_buffer.sv
      - verilog/aes_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/aes_top_assertions.sv
      - tb/aes_top_tb.sv
